// ==== src.f ====
design/recovery_pkg.sv
design/recovery_fsm.sv
design/payload_counter.sv
design/pec_crc8.sv
design/cmd_header_regs.sv
design/payload_buffer.sv
design/recovery_rx_top.sv
dv/tb_recovery_rx.sv

// ==== Bender.yml ====
package:
  name: recovery_rx

sources:
  - files:
      - design/recovery_pkg.sv
      - design/recovery_fsm.sv
      - design/payload_counter.sv
      - design/pec_crc8.sv
      - design/cmd_header_regs.sv
      - design/payload_buffer.sv
      - design/recovery_rx_top.sv
  - target: test
    files:
      - dv/tb_recovery_rx.sv

// ==== dv/tb_recovery_rx.sv ====
`timescale 1ns/1ps

module tb_recovery_rx;

    localparam int unsigned Depth = 16;
    localparam int unsigned AddrW = $clog2(Depth);
    localparam int Timeout = 400;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                byte_valid;
    recovery_pkg::byte_t byte_data;
    logic                bus_start;
    logic                bus_stop;
    logic                cmd_done;
    logic [AddrW-1:0]    rd_addr;
    logic                cmd_valid;
    logic                cmd_is_rd;
    recovery_pkg::byte_t cmd;
    recovery_pkg::len_t  cmd_len;
    logic                cmd_error;
    recovery_pkg::byte_t rd_data;

    // Expected command of the frame in flight
    string               test_name;
    recovery_pkg::byte_t exp_cmd;
    recovery_pkg::len_t  exp_len;
    logic                exp_is_rd;
    logic                exp_error;
    recovery_pkg::byte_t payload_q[$];

    integer seed;
    int     checks_done;

    recovery_rx_top #(
        .PayloadDepth (Depth)
    ) dut0 (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .byte_valid_i (byte_valid),
        .byte_i       (byte_data),
        .bus_start_i  (bus_start),
        .bus_stop_i   (bus_stop),
        .cmd_done_i   (cmd_done),
        .rd_addr_i    (rd_addr),
        .cmd_valid_o  (cmd_valid),
        .cmd_is_rd_o  (cmd_is_rd),
        .cmd_o        (cmd),
        .cmd_len_o    (cmd_len),
        .cmd_error_o  (cmd_error),
        .rd_data_o    (rd_data)
    );

    always #5 clk = ~clk;

    // Serial LFSR form of the SMBus CRC-8, data MSB first
    function automatic recovery_pkg::byte_t crc8(input recovery_pkg::byte_t crc,
                                                 input recovery_pkg::byte_t data);
        recovery_pkg::byte_t poly;
        recovery_pkg::byte_t c;
        logic                fb;
        poly = 8'h07;
        c = crc;
        for (int b = 7; b >= 0; b--) begin
            fb = c[7] ^ data[b];
            c = {c[6:0], 1'b0};
            if (fb) c = c ^ poly;
        end
        return c;
    endfunction

    // Expected PEC over every byte before the PEC byte
    function automatic recovery_pkg::byte_t frame_pec(input logic is_write);
        recovery_pkg::byte_t crc;
        crc = crc8(8'h00, exp_cmd);
        if (is_write) begin
            crc = crc8(crc, exp_len[7:0]);
            crc = crc8(crc, exp_len[15:8]);
            foreach (payload_q[i]) crc = crc8(crc, payload_q[i]);
        end
        return crc;
    endfunction

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks_done++;
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", test_name, field,
                     expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic bus_cycle(input logic valid, input recovery_pkg::byte_t data,
                             input logic start, input logic stop);
        @(negedge clk);
        byte_valid = valid;
        byte_data  = data;
        bus_start  = start;
        bus_stop   = stop;
    endtask

    // Zero to two quiet cycles
    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) bus_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic send_byte(input recovery_pkg::byte_t data);
        idle_gap();
        bus_cycle(1'b1, data, 1'b0, 1'b0);
    endtask

    task automatic send_strobe(input logic start, input logic stop);
        idle_gap();
        bus_cycle(1'b0, 8'h00, start, stop);
    endtask

    // Stop after abort_at payload bytes when abort_at is not negative
    task automatic send_write(input recovery_pkg::byte_t pec, input int abort_at);
        send_strobe(1'b1, 1'b0);
        send_byte(exp_cmd);
        send_byte(exp_len[7:0]);
        send_byte(exp_len[15:8]);
        for (int i = 0; i < payload_q.size(); i++) begin
            if (i == abort_at) send_strobe(1'b0, 1'b1);
            send_byte(payload_q[i]);
        end
        send_byte(pec);
        send_strobe(1'b0, 1'b1);
        bus_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic send_read(input recovery_pkg::byte_t pec);
        send_strobe(1'b1, 1'b0);
        send_byte(exp_cmd);
        send_byte(pec);
        send_strobe(1'b1, 1'b0);
        bus_cycle(1'b0, 8'h00, 1'b0, 1'b0);
    endtask

    task automatic prepare_write(input recovery_pkg::len_t len);
        payload_q.delete();
        exp_cmd   = recovery_pkg::byte_t'($random(seed));
        exp_len   = len;
        exp_is_rd = 1'b0;
        for (int i = 0; i < len; i++) begin
            payload_q.push_back(recovery_pkg::byte_t'($random(seed)));
        end
    endtask

    task automatic prepare_read();
        payload_q.delete();
        exp_cmd   = recovery_pkg::byte_t'($random(seed));
        exp_len   = '0;
        exp_is_rd = 1'b1;
    endtask

    // Comparing side, runs next to the frame driver
    task automatic await_command();
        int cycles;
        int rd_count;
        cycles = 0;
        rd_count = (exp_len > Depth) ? Depth : exp_len;
        while (cmd_valid !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > Timeout) begin
                $display("ERROR %s: cmd_valid_o did not rise within %0d cycles",
                         test_name, Timeout);
                stop_with_failure();
            end
        end
        check_value("cmd_is_rd_o", exp_is_rd, cmd_is_rd);
        check_value("cmd_o", exp_cmd, cmd);
        check_value("cmd_len_o", exp_len, cmd_len);
        check_value("cmd_error_o", exp_error, cmd_error);
        @(negedge clk);
        check_value("cmd_valid_o width", 1'b0, cmd_valid);
        for (int i = 0; i < rd_count; i++) begin
            rd_addr = AddrW'(i);
            @(negedge clk);
            check_value($sformatf("payload[%0d]", i), payload_q[i], rd_data);
        end
        // Fields hold while busy
        check_value("cmd_o held", exp_cmd, cmd);
        check_value("cmd_len_o held", exp_len, cmd_len);
        cmd_done = 1'b1;
        @(negedge clk);
        cmd_done = 1'b0;
    endtask

    task automatic expect_no_command(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            checks_done++;
            if (cmd_valid !== 1'b0) begin
                $display("ERROR %s: cmd_valid_o rose for an abandoned frame", test_name);
                stop_with_failure();
            end
        end
    endtask

    task automatic run_write(input recovery_pkg::byte_t pec);
        exp_error = (pec !== frame_pec(1'b1)) || (exp_len > Depth);
        fork
            send_write(pec, -1);
            await_command();
        join
    endtask

    task automatic run_read(input recovery_pkg::byte_t pec);
        exp_error = (pec !== frame_pec(1'b0));
        fork
            send_read(pec);
            await_command();
        join
    endtask

    initial begin
        recovery_pkg::byte_t flip;
        seed        = 32'he54a;
        checks_done = 0;
        rst_n       = 1'b0;
        byte_valid  = 1'b0;
        byte_data   = '0;
        bus_start   = 1'b0;
        bus_stop    = 1'b0;
        cmd_done    = 1'b0;
        rd_addr     = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        test_name = "reset";
        check_value("cmd_valid_o", 1'b0, cmd_valid);
        check_value("cmd_is_rd_o", 1'b0, cmd_is_rd);

        test_name = "write_good_pec";
        repeat (4) begin
            prepare_write(recovery_pkg::len_t'(1 + ($unsigned($random(seed)) % Depth)));
            run_write(frame_pec(1'b1));
        end

        // Same frame again with one PEC bit flipped
        test_name = "write_bad_pec";
        flip = 8'h01 << ($unsigned($random(seed)) % 8);
        run_write(frame_pec(1'b1) ^ flip);

        test_name = "read_good_pec";
        prepare_read();
        run_read(frame_pec(1'b0));

        test_name = "read_bad_pec";
        prepare_read();
        flip = 8'h01 << ($unsigned($random(seed)) % 8);
        run_read(frame_pec(1'b0) ^ flip);

        test_name = "write_zero_len";
        prepare_write(16'd0);
        run_write(frame_pec(1'b1));

        // Remaining payload and PEC bytes land in Idle and are dropped
        test_name = "stop_mid_frame";
        prepare_write(16'd8);
        fork
            send_write(frame_pec(1'b1), 3);
            expect_no_command(100);
        join

        test_name = "write_after_stop";
        prepare_write(recovery_pkg::len_t'(1 + ($unsigned($random(seed)) % Depth)));
        run_write(frame_pec(1'b1));

        test_name = "write_oversized";
        prepare_write(16'd20);
        run_write(frame_pec(1'b1));

        if (checks_done > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("ERROR no checks were executed");
            stop_with_failure();
        end
    end

endmodule

// ==== design/recovery_rx_top.sv ====
`timescale 1ns/1ps

module recovery_rx_top #(
    parameter int unsigned PayloadDepth = 64
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         byte_valid_i,
    input  recovery_pkg::byte_t                          byte_i,
    input  logic                                         bus_start_i,
    input  logic                                         bus_stop_i,
    input  logic                                         cmd_done_i,
    input  logic [((PayloadDepth > 1) ? $clog2(PayloadDepth) : 1)-1:0] rd_addr_i,
    output logic                                         cmd_valid_o,
    output logic                                         cmd_is_rd_o,
    output recovery_pkg::byte_t                          cmd_o,
    output recovery_pkg::len_t                           cmd_len_o,
    output logic                                         cmd_error_o,
    output recovery_pkg::byte_t                          rd_data_o
);

    logic cap_cmd;
    logic cap_len_l;
    logic cap_len_h;
    logic cap_pec;
    logic cap_rd;
    logic cnt_load;
    logic cnt_dec;
    logic buf_wr;
    logic pec_enable;
    logic count_zero;
    logic overflow;

    recovery_pkg::len_t  wr_index;
    recovery_pkg::byte_t crc;

    recovery_fsm u_fsm (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .byte_valid_i (byte_valid_i),
        .bus_start_i  (bus_start_i),
        .bus_stop_i   (bus_stop_i),
        .count_zero_i (count_zero),
        .cmd_done_i   (cmd_done_i),
        .cap_cmd_o    (cap_cmd),
        .cap_len_l_o  (cap_len_l),
        .cap_len_h_o  (cap_len_h),
        .cap_pec_o    (cap_pec),
        .cap_rd_o     (cap_rd),
        .cnt_load_o   (cnt_load),
        .cnt_dec_o    (cnt_dec),
        .buf_wr_o     (buf_wr),
        .pec_enable_o (pec_enable),
        .cmd_valid_o  (cmd_valid_o),
        .cmd_is_rd_o  (cmd_is_rd_o)
    );

    // Length loads as the high byte arrives, low byte is already held
    payload_counter u_counter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .load_i       (cnt_load),
        .len_i        ({byte_i, cmd_len_o[7:0]}),
        .dec_i        (cnt_dec),
        .count_zero_o (count_zero),
        .wr_index_o   (wr_index)
    );

    pec_crc8 u_crc (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .clear_i  (bus_start_i),
        .enable_i (pec_enable),
        .byte_i   (byte_i),
        .crc_o    (crc)
    );

    cmd_header_regs u_hdr (
        .clk_i       (clk_i),
        .byte_i      (byte_i),
        .cap_cmd_i   (cap_cmd),
        .cap_len_l_i (cap_len_l),
        .cap_len_h_i (cap_len_h),
        .cap_pec_i   (cap_pec),
        .cap_rd_i    (cap_rd),
        .crc_i       (crc),
        .overflow_i  (overflow),
        .cmd_o       (cmd_o),
        .len_o       (cmd_len_o),
        .error_o     (cmd_error_o)
    );

    payload_buffer #(
        .PayloadDepth (PayloadDepth)
    ) u_buf (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .wr_i       (buf_wr),
        .wr_index_i (wr_index),
        .byte_i     (byte_i),
        .clear_i    (cnt_load),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o),
        .overflow_o (overflow)
    );

endmodule

// ==== design/payload_buffer.sv ====
`timescale 1ns/1ps

module payload_buffer #(
    parameter int unsigned PayloadDepth = 64
) (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    input  logic                                         wr_i,
    input  recovery_pkg::len_t                           wr_index_i,
    input  recovery_pkg::byte_t                          byte_i,
    input  logic                                         clear_i,
    input  logic [((PayloadDepth > 1) ? $clog2(PayloadDepth) : 1)-1:0] rd_addr_i,
    output recovery_pkg::byte_t                          rd_data_o,
    output logic                                         overflow_o
);

    localparam int unsigned AddrW = (PayloadDepth > 1) ? $clog2(PayloadDepth) : 1;
    localparam recovery_pkg::len_t DepthLen = recovery_pkg::len_t'(PayloadDepth);

    recovery_pkg::byte_t mem [PayloadDepth];
    logic                in_range;
    logic                ovf_q;

    assign in_range = (wr_index_i < DepthLen);

    always_ff @(posedge clk_i) begin
        if (wr_i && in_range) begin
            mem[wr_index_i[AddrW-1:0]] <= byte_i;
        end
    end

    // Sticky until the next length load
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ovf_q <= 1'b0;
        end else if (clear_i) begin
            ovf_q <= 1'b0;
        end else if (wr_i && !in_range) begin
            ovf_q <= 1'b1;
        end
    end

    // Addresses past a non power of two depth read as zero
    assign rd_data_o  = (rd_addr_i < PayloadDepth) ? mem[rd_addr_i] : '0;
    assign overflow_o = ovf_q;

    a_wr_index_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wr_i |-> !$isunknown(wr_index_i));

endmodule

// ==== design/cmd_header_regs.sv ====
`timescale 1ns/1ps

module cmd_header_regs (
    input  logic                clk_i,
    input  recovery_pkg::byte_t byte_i,
    input  logic                cap_cmd_i,
    input  logic                cap_len_l_i,
    input  logic                cap_len_h_i,
    input  logic                cap_pec_i,
    input  logic                cap_rd_i,
    input  recovery_pkg::byte_t crc_i,
    input  logic                overflow_i,
    output recovery_pkg::byte_t cmd_o,
    output recovery_pkg::len_t  len_o,
    output logic                error_o
);

    recovery_pkg::byte_t cmd_q;
    recovery_pkg::byte_t len_l_q;
    recovery_pkg::byte_t len_h_q;
    recovery_pkg::byte_t pec_rx_q;
    recovery_pkg::byte_t pec_calc_q;
    logic                ovf_q;

    always_ff @(posedge clk_i) begin
        if (cap_cmd_i) cmd_q <= byte_i;
        if (cap_len_l_i) len_l_q <= byte_i;
        if (cap_len_h_i) len_h_q <= byte_i;
        if (cap_pec_i) pec_rx_q <= byte_i;

        // On a read the "length low" byte was really the PEC
        if (cap_rd_i) begin
            pec_rx_q <= len_l_q;
            len_l_q  <= '0;
            len_h_q  <= '0;
        end
    end

    // CRC output still excludes the byte sampled on this edge
    always_ff @(posedge clk_i) begin
        if (cap_pec_i || cap_len_l_i) begin
            pec_calc_q <= crc_i;
        end
    end

    // Overflow only counts for writes
    always_ff @(posedge clk_i) begin
        if (cap_pec_i) ovf_q <= overflow_i;
        else if (cap_rd_i) ovf_q <= 1'b0;
    end

    assign cmd_o   = cmd_q;
    assign len_o   = {len_h_q, len_l_q};
    assign error_o = (pec_calc_q != pec_rx_q) || ovf_q;

endmodule

// ==== design/pec_crc8.sv ====
`timescale 1ns/1ps

module pec_crc8 (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                enable_i,
    input  recovery_pkg::byte_t byte_i,
    output recovery_pkg::byte_t crc_o
);

    recovery_pkg::byte_t crc_q;

    // MSB first, one byte per call
    function automatic recovery_pkg::byte_t crc_step(recovery_pkg::byte_t crc,
                                                     recovery_pkg::byte_t data);
        recovery_pkg::byte_t c;
        c = crc ^ data;
        for (int i = 0; i < 8; i++) begin
            if (c[7]) c = (c << 1) ^ recovery_pkg::PecPoly;
            else c = c << 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            crc_q <= '0;
        end else if (clear_i) begin
            crc_q <= '0;
        end else if (enable_i) begin
            crc_q <= crc_step(crc_q, byte_i);
        end
    end

    assign crc_o = crc_q;

endmodule

// ==== design/payload_counter.sv ====
`timescale 1ns/1ps

module payload_counter (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               load_i,
    input  recovery_pkg::len_t len_i,
    input  logic               dec_i,
    output logic               count_zero_o,
    output recovery_pkg::len_t wr_index_o
);

    recovery_pkg::len_t count_q;
    recovery_pkg::len_t count_d;
    recovery_pkg::len_t index_q;

    // Next remaining count, also drives the zero flag
    always_comb begin
        count_d = count_q;
        if (load_i) begin
            count_d = len_i;
        end else if (dec_i) begin
            count_d = count_q - 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            count_q <= '0;
            index_q <= '0;
        end else begin
            count_q <= count_d;
            if (load_i) begin
                index_q <= '0;
            end else if (dec_i) begin
                index_q <= index_q + 16'd1;
            end
        end
    end

    // Tells the FSM whether this byte was the last one
    assign count_zero_o = (count_d == '0);
    assign wr_index_o   = index_q;

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dec_i |-> (count_q != '0));

endmodule

// ==== design/recovery_fsm.sv ====
`timescale 1ns/1ps

module recovery_fsm (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic byte_valid_i,
    input  logic bus_start_i,
    input  logic bus_stop_i,
    input  logic count_zero_i,
    input  logic cmd_done_i,
    output logic cap_cmd_o,
    output logic cap_len_l_o,
    output logic cap_len_h_o,
    output logic cap_pec_o,
    output logic cap_rd_o,
    output logic cnt_load_o,
    output logic cnt_dec_o,
    output logic buf_wr_o,
    output logic pec_enable_o,
    output logic cmd_valid_o,
    output logic cmd_is_rd_o
);

    recovery_pkg::rx_state_e state_q;
    recovery_pkg::rx_state_e state_d;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            state_q <= recovery_pkg::Idle;
        end else begin
            state_q <= state_d;
        end
    end

    // A byte wins over a stop in the same cycle
    always_comb begin
        state_d = state_q;
        case (state_q)
            recovery_pkg::Idle: begin
                if (bus_start_i) state_d = recovery_pkg::RxCmd;
            end
            recovery_pkg::RxCmd: begin
                if (byte_valid_i) state_d = recovery_pkg::RxLenL;
                else if (bus_stop_i) state_d = recovery_pkg::Idle;
            end
            recovery_pkg::RxLenL: begin
                if (byte_valid_i) state_d = recovery_pkg::RxLenH;
                else if (bus_stop_i) state_d = recovery_pkg::Idle;
            end
            // Repeated start here means the frame was a read
            recovery_pkg::RxLenH: begin
                if (byte_valid_i) begin
                    state_d = count_zero_i ? recovery_pkg::RxPec : recovery_pkg::RxData;
                end else if (bus_start_i) begin
                    state_d = recovery_pkg::CmdIsRd;
                end else if (bus_stop_i) begin
                    state_d = recovery_pkg::Idle;
                end
            end
            // count_zero_i already accounts for this cycle's decrement
            recovery_pkg::RxData: begin
                if (byte_valid_i && count_zero_i) state_d = recovery_pkg::RxPec;
                else if (!byte_valid_i && bus_stop_i) state_d = recovery_pkg::Idle;
            end
            recovery_pkg::RxPec: begin
                if (byte_valid_i) state_d = recovery_pkg::Cmd;
                else if (bus_stop_i) state_d = recovery_pkg::Idle;
            end
            recovery_pkg::CmdIsRd: state_d = recovery_pkg::Cmd;
            recovery_pkg::Cmd:     state_d = recovery_pkg::Busy;
            recovery_pkg::Busy: begin
                if (cmd_done_i) state_d = recovery_pkg::Idle;
            end
            default: state_d = recovery_pkg::Idle;
        endcase
    end

    // One strobe per accepted byte
    assign cap_cmd_o   = byte_valid_i && (state_q == recovery_pkg::RxCmd);
    assign cap_len_l_o = byte_valid_i && (state_q == recovery_pkg::RxLenL);
    assign cap_len_h_o = byte_valid_i && (state_q == recovery_pkg::RxLenH);
    assign cap_pec_o   = byte_valid_i && (state_q == recovery_pkg::RxPec);
    assign buf_wr_o    = byte_valid_i && (state_q == recovery_pkg::RxData);
    assign cap_rd_o    = (state_q == recovery_pkg::CmdIsRd);

    // Length is complete once the high byte arrives
    assign cnt_load_o = cap_len_h_o;
    assign cnt_dec_o  = buf_wr_o;

    // PEC covers header and payload, never the PEC byte itself
    assign pec_enable_o = cap_cmd_o | cap_len_l_o | cap_len_h_o | buf_wr_o;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cmd_valid_o <= 1'b0;
            cmd_is_rd_o <= 1'b0;
        end else begin
            cmd_valid_o <= (state_q == recovery_pkg::Cmd);
            if (state_q == recovery_pkg::CmdIsRd) begin
                cmd_is_rd_o <= 1'b1;
            end else if (state_q == recovery_pkg::Idle && bus_start_i) begin
                cmd_is_rd_o <= 1'b0;
            end
        end
    end

    a_cmd_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_valid_o |=> !cmd_valid_o);

endmodule

// ==== design/recovery_pkg.sv ====
package recovery_pkg;

    // One byte as seen on the bus
    typedef logic [7:0] byte_t;

    // Payload length and remaining count
    typedef logic [15:0] len_t;

    // Frame parser states
    // Upper nibble groups the header, payload, PEC and command phases
    typedef enum logic [7:0] {
        Idle    = 8'h00,
        RxCmd   = 8'h10,
        RxLenL  = 8'h11,
        RxLenH  = 8'h12,
        RxData  = 8'h20,
        RxPec   = 8'h30,
        CmdIsRd = 8'h38,
        Cmd     = 8'h40,
        Busy    = 8'h41
    } rx_state_e;

    // SMBus PEC generator x^8 + x^2 + x + 1
    localparam byte_t PecPoly = 8'h07;

endpackage
